// File: src/carrierLoop_consts.svh
`ifndef CARRIERLOOP_CONSTS_SVH
`define CARRIERLOOP_CONSTS_SVH

// ------------------------------------------------------------
// Host address space
// ------------------------------------------------------------
`define LOOP_SPACE    4'h6          // Matched against adr[11:8]

// Word offsets within the block, adr[7:0]
`define REG_CONTROL   8'h00
`define REG_GAINS     8'h04
`define REG_LIMIT     8'h08
`define REG_LOCK      8'h0C
`define REG_STATUS    8'h10
`define REG_LAGACCUM  8'h14
`define REG_FREQ      8'h18

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
`define SAMPLE_W      18            // I/Q sample width
`define ACCUM_W       40            // Lag accumulator and filter sum

`define MIX_LATENCY   4             // Mixer pipeline depth in clocks

// Peak LO amplitude, full scale of an 18 bit signed value
`define NCO_AMP       131071

`endif

// File: src/carrierLoopPkg.sv
`default_nettype none
`include "carrierLoop_consts.svh"

package carrierLoopPkg;

  // ------------------------------------------------------------
  // Sample path
  // ------------------------------------------------------------
  typedef struct packed {
    logic signed [`SAMPLE_W-1:0] re;
    logic signed [`SAMPLE_W-1:0] im;
  } iqSample_t;

  // ------------------------------------------------------------
  // Loop configuration from the register bank
  // ------------------------------------------------------------
  typedef struct packed {
    logic        invertError;     // Negate the phase error
    logic        zeroError;       // Open the loop
    logic        clearAccum;      // Hold lag accumulator at zero
    logic [4:0]  leadExp;
    logic [4:0]  lagExp;
    logic [31:0] limit;           // Lag magnitude, upper 32 bits
    logic [15:0] lockCount;       // Lock counter reload value
    logic [7:0]  syncThreshold;
    logic        loadLock;        // Single cycle pulse
  } loopConfig_t;

  // ------------------------------------------------------------
  // Loop status for readback
  // ------------------------------------------------------------
  typedef struct packed {
    logic        carrierLock;
    logic [15:0] lockCounter;
    logic [31:0] lagAccum;        // Upper bits of the accumulator
    logic [31:0] freqOffset;
  } loopStatus_t;

endpackage

`default_nettype wire

// File: src/loopRegs.sv
`default_nettype none
`include "carrierLoop_consts.svh"

module loopRegs import carrierLoopPkg::*; (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        cyc,
  input  wire logic        stb,
  input  wire logic        we,
  input  wire logic [11:0] adr,
  input  wire logic [3:0]  sel,
  input  wire logic [31:0] datIn,
  input  wire loopStatus_t status,
  output logic      [31:0] datOut,
  output logic             ack,
  output loopConfig_t      cfg
);

  logic        spaceHit;
  logic        access;
  logic        writeEn;
  logic [31:0] curWord;
  logic [31:0] newWord;

  logic [2:0]  controlReg;        // {clearAccum, zeroError, invertError}
  logic [4:0]  leadExpReg;
  logic [4:0]  lagExpReg;
  logic [31:0] limitReg;
  logic [15:0] lockCountReg;
  logic [7:0]  syncThreshReg;
  logic        loadLockReg;

  function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                             input logic [31:0] wrData,
                                             input logic [3:0]  byteEn);
    logic [31:0] result;
    result = oldWord;
    for (int i = 0; i < 4; i++) begin
      if (byteEn[i]) result[8*i +: 8] = wrData[8*i +: 8];
    end
    return result;
  endfunction

  // ------------------------------------------------------------
  // Bus decode
  // ------------------------------------------------------------
  assign spaceHit = (adr[11:8] == `LOOP_SPACE);
  assign access   = cyc && stb && spaceHit && !ack;   // No back to back ack
  assign writeEn  = access && we;

  // Readback mux, also the base word for partial writes
  always_comb begin
    case (adr[7:0])
      `REG_CONTROL:  curWord = {29'd0, controlReg};
      `REG_GAINS:    curWord = {19'd0, lagExpReg, 3'd0, leadExpReg};
      `REG_LIMIT:    curWord = limitReg;
      `REG_LOCK:     curWord = {8'd0, syncThreshReg, lockCountReg};
      `REG_STATUS:   curWord = {15'd0, status.carrierLock, status.lockCounter};
      `REG_LAGACCUM: curWord = status.lagAccum;
      `REG_FREQ:     curWord = status.freqOffset;
      default:       curWord = 32'd0;
    endcase
  end

  assign newWord = mergeBytes(curWord, datIn, sel);
  assign datOut  = curWord;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack           <= 1'b0;
      controlReg    <= '0;
      leadExpReg    <= '0;
      lagExpReg     <= '0;
      limitReg      <= '0;
      lockCountReg  <= '0;
      syncThreshReg <= '0;
      loadLockReg   <= 1'b0;
    end else begin
      ack         <= access;
      loadLockReg <= writeEn && (adr[7:0] == `REG_LOCK);
      if (writeEn) begin
        case (adr[7:0])
          `REG_CONTROL: controlReg <= newWord[2:0];
          `REG_GAINS: begin
            leadExpReg <= newWord[4:0];
            lagExpReg  <= newWord[12:8];
          end
          `REG_LIMIT: limitReg <= newWord;
          `REG_LOCK: begin
            lockCountReg  <= newWord[15:0];
            syncThreshReg <= newWord[23:16];
          end
          default: ;                // Status words are read only
        endcase
      end
    end
  end

  assign cfg = '{invertError:   controlReg[0],
                 zeroError:     controlReg[1],
                 clearAccum:    controlReg[2],
                 leadExp:       leadExpReg,
                 lagExp:        lagExpReg,
                 limit:         limitReg,
                 lockCount:     lockCountReg,
                 syncThreshold: syncThreshReg,
                 loadLock:      loadLockReg};

endmodule

`default_nettype wire

// File: src/carrierLoopCtrl.sv
`default_nettype none
`include "carrierLoop_consts.svh"

module carrierLoopCtrl import carrierLoopPkg::*; (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        symEn,
  input  wire logic        sym2xEn,
  input  wire logic [7:0]  phaseError,
  input  wire loopConfig_t cfg,
  output logic             symEnOut,
  output logic             sym2xEnOut,
  output logic             loopEn,
  output logic      [7:0]  loopError,
  output logic             carrierLock,
  output logic      [15:0] lockCounter
);

  logic [`MIX_LATENCY-1:0] symEnSr;
  logic [`MIX_LATENCY-1:0] sym2xEnSr;

  logic [7:0]  negError;
  logic [7:0]  absError;
  logic        inSync;
  logic [16:0] lockPlus;
  logic [16:0] lockMinus;

  // ------------------------------------------------------------
  // Strobe alignment with the mixer output
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      symEnSr   <= '0;
      sym2xEnSr <= '0;
    end else begin
      symEnSr   <= {symEnSr[`MIX_LATENCY-2:0], symEn};
      sym2xEnSr <= {sym2xEnSr[`MIX_LATENCY-2:0], sym2xEn};
    end
  end

  assign symEnOut   = symEnSr[`MIX_LATENCY-1];
  assign sym2xEnOut = sym2xEnSr[`MIX_LATENCY-1];
  assign loopEn     = sym2xEnOut;   // Error belongs to the delayed sample

  // ------------------------------------------------------------
  // Error conditioning
  // ------------------------------------------------------------
  assign negError = ~phaseError + 8'd1;

  always_comb begin
    if (cfg.zeroError)
      loopError = 8'd0;
    else if (cfg.invertError)
      loopError = negError;
    else
      loopError = phaseError;
  end

  // ------------------------------------------------------------
  // Lock detector
  // ------------------------------------------------------------
  // Magnitude of -128 reads as 128 here
  assign absError  = phaseError[7] ? negError : phaseError;
  assign inSync    = (absError <= cfg.syncThreshold);
  assign lockPlus  = {1'b0, lockCounter} + 17'h00001;
  assign lockMinus = {1'b0, lockCounter} + 17'h1FFFF;   // Borrow shows in bit 16

  always_ff @(posedge clk) begin
    if (reset) begin
      lockCounter <= '0;
      carrierLock <= 1'b0;
    end else if (cfg.loadLock) begin
      lockCounter <= cfg.lockCount;
    end else if (loopEn) begin
      if (inSync) begin
        if (lockPlus[16]) begin
          carrierLock <= 1'b1;
          lockCounter <= cfg.lockCount;
        end else begin
          lockCounter <= lockPlus[15:0];
        end
      end else begin
        if (lockMinus[16]) begin
          carrierLock <= 1'b0;          // Counter ran out
          lockCounter <= cfg.lockCount;
        end else begin
          lockCounter <= lockMinus[15:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/loopFilter.sv
`default_nettype none
`include "carrierLoop_consts.svh"

module loopFilter import carrierLoopPkg::*; (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        loopEn,
  input  wire logic [7:0]  loopError,
  input  wire loopConfig_t cfg,
  output logic      [31:0] lagAccum,
  output logic      [31:0] freqOffset
);

  logic signed [`ACCUM_W-1:0] errExt;
  logic signed [`ACCUM_W-1:0] leadTerm;
  logic signed [`ACCUM_W-1:0] lagStep;
  logic signed [`ACCUM_W-1:0] lagReg;
  logic signed [`ACCUM_W-1:0] filterSum;

  // One guard bit so the sum and limits cannot wrap
  logic signed [`ACCUM_W:0] lagSum;
  logic signed [`ACCUM_W:0] posLimit;
  logic signed [`ACCUM_W:0] negLimit;
  logic signed [`ACCUM_W:0] lagClamped;

  // ------------------------------------------------------------
  // Lead and lag gains
  // ------------------------------------------------------------
  assign errExt   = {{(`ACCUM_W-8){loopError[7]}}, loopError};
  assign leadTerm = errExt <<< cfg.leadExp;
  assign lagStep  = errExt <<< cfg.lagExp;

  assign lagSum   = lagReg + lagStep;
  assign posLimit = {1'b0, cfg.limit, 8'd0};   // Limit sits in the upper 32 bits
  assign negLimit = -posLimit;

  always_comb begin
    if (lagSum > posLimit)
      lagClamped = posLimit;
    else if (lagSum < negLimit)
      lagClamped = negLimit;
    else
      lagClamped = lagSum;
  end

  // ------------------------------------------------------------
  // Lag accumulator and filter sum
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      lagReg <= '0;
    end else if (cfg.clearAccum) begin
      lagReg <= '0;
    end else if (loopEn) begin
      lagReg <= lagClamped[`ACCUM_W-1:0];
    end
  end

  // Sum uses the lag value from before this update
  always_ff @(posedge clk) begin
    if (reset)
      filterSum <= '0;
    else if (loopEn)
      filterSum <= lagReg + leadTerm;
  end

  assign lagAccum   = lagReg[`ACCUM_W-1 -: 32];
  assign freqOffset = filterSum[`ACCUM_W-1 -: 32];

endmodule

`default_nettype wire

// File: src/carrierNco.sv
`default_nettype none
`include "carrierLoop_consts.svh"

module carrierNco import carrierLoopPkg::*; (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        sym2xEn,
  input  wire logic [31:0] freqOffset,
  output iqSample_t        lo
);

  logic [31:0] phase;
  logic [1:0]  quadrant;
  logic [4:0]  idx;
  logic [4:0]  idxRev;
  logic signed [`SAMPLE_W-1:0] sinMag;
  logic signed [`SAMPLE_W-1:0] cosMag;
  logic signed [`SAMPLE_W-1:0] cosVal;
  logic signed [`SAMPLE_W-1:0] sinVal;

  // First quadrant of sine, 16 steps per quarter, entry 16 is the peak
  function automatic logic signed [`SAMPLE_W-1:0] quarterSine(input logic [4:0] k);
    case (k)
      5'd0:    return 0;
      5'd1:    return 12847;
      5'd2:    return 25571;
      5'd3:    return 38048;
      5'd4:    return 50158;
      5'd5:    return 61786;
      5'd6:    return 72819;
      5'd7:    return 83151;
      5'd8:    return 92681;
      5'd9:    return 101319;
      5'd10:   return 108982;
      5'd11:   return 115594;
      5'd12:   return 121094;
      5'd13:   return 125427;
      5'd14:   return 128553;
      5'd15:   return 130440;
      default: return `NCO_AMP;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (reset)
      phase <= '0;
    else if (sym2xEn)
      phase <= phase + freqOffset;
  end

  // ------------------------------------------------------------
  // Quadrant folding
  // ------------------------------------------------------------
  assign quadrant = phase[31:30];
  assign idx      = {1'b0, phase[29:26]};
  assign idxRev   = 5'd16 - idx;
  assign sinMag   = quarterSine(idx);
  assign cosMag   = quarterSine(idxRev);

  always_comb begin
    case (quadrant)
      2'd0: begin cosVal = cosMag;  sinVal = sinMag;  end
      2'd1: begin cosVal = -sinMag; sinVal = cosMag;  end
      2'd2: begin cosVal = -cosMag; sinVal = -sinMag; end
      default: begin cosVal = sinMag; sinVal = -cosMag; end
    endcase
  end

  // Negated sine rotates the input back by the NCO phase
  always_ff @(posedge clk) begin
    lo.re <= cosVal;
    lo.im <= -sinVal;
  end

endmodule

`default_nettype wire

// File: src/complexMixer.sv
`default_nettype none
`include "carrierLoop_consts.svh"

module complexMixer import carrierLoopPkg::*; (
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire iqSample_t a,
  input  wire iqSample_t b,
  output iqSample_t      p
);

  localparam int W = `SAMPLE_W;
  localparam logic signed [W-1:0] SAT_MAX = {1'b0, {(W-1){1'b1}}};
  localparam logic signed [W-1:0] SAT_MIN = {1'b1, {(W-1){1'b0}}};

  iqSample_t               aReg;
  iqSample_t               bReg;
  logic signed [2*W-1:0]   prodRr;
  logic signed [2*W-1:0]   prodIi;
  logic signed [2*W-1:0]   prodRi;
  logic signed [2*W-1:0]   prodIr;
  logic signed [2*W:0]     sumRe;
  logic signed [2*W:0]     sumIm;

  // Scale back by 2^17 then clip to the sample range
  function automatic logic signed [W-1:0] scaleSat(input logic signed [2*W:0] x);
    logic signed [2*W:0] shifted;
    shifted = x >>> (W - 1);
    if (shifted > SAT_MAX)
      return SAT_MAX;
    else if (shifted < SAT_MIN)
      return SAT_MIN;
    else
      return shifted[W-1:0];
  endfunction

  // ------------------------------------------------------------
  // Pipeline stages 1 to 3
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    aReg   <= a;
    bReg   <= b;
    prodRr <= aReg.re * bReg.re;
    prodIi <= aReg.im * bReg.im;
    prodRi <= aReg.re * bReg.im;
    prodIr <= aReg.im * bReg.re;
    sumRe  <= prodRr - prodIi;
    sumIm  <= prodRi + prodIr;
  end

  // Stage 4
  always_ff @(posedge clk) begin
    if (reset) begin
      p <= '0;
    end else begin
      p.re <= scaleSat(sumRe);
      p.im <= scaleSat(sumIm);
    end
  end

endmodule

`default_nettype wire

// File: src/carrierLoop.sv
`default_nettype none

module carrierLoop import carrierLoopPkg::*; (
  input  wire logic        clk,
  input  wire logic        reset,
  // Host bus
  input  wire logic        cyc,
  input  wire logic        stb,
  input  wire logic        we,
  input  wire logic [11:0] adr,
  input  wire logic [3:0]  sel,
  input  wire logic [31:0] datIn,
  output logic      [31:0] datOut,
  output logic             ack,
  // Sample path
  input  wire iqSample_t   in,
  input  wire logic        symEn,
  input  wire logic        sym2xEn,
  input  wire logic [7:0]  phaseError,
  output iqSample_t        out,
  output logic             symEnOut,
  output logic             sym2xEnOut,
  output logic             carrierLock
);

  loopConfig_t cfg;
  loopStatus_t status;
  iqSample_t   lo;
  logic        loopEn;
  logic [7:0]  loopError;
  logic [15:0] lockCounter;
  logic [31:0] lagAccum;
  logic [31:0] freqOffset;

  assign status = '{carrierLock: carrierLock,
                    lockCounter: lockCounter,
                    lagAccum:    lagAccum,
                    freqOffset:  freqOffset};

  // ------------------------------------------------------------
  // Control and loop filter
  // ------------------------------------------------------------
  loopRegs regs (.clk, .reset, .cyc, .stb, .we, .adr, .sel, .datIn,
                 .status, .datOut, .ack, .cfg);

  carrierLoopCtrl ctrl (.clk, .reset, .symEn, .sym2xEn, .phaseError, .cfg,
                        .symEnOut, .sym2xEnOut, .loopEn, .loopError,
                        .carrierLock, .lockCounter);

  loopFilter filter (.clk, .reset, .loopEn, .loopError, .cfg,
                     .lagAccum, .freqOffset);

  // ------------------------------------------------------------
  // LO generation and derotation
  // ------------------------------------------------------------
  carrierNco nco (.clk, .reset, .sym2xEn, .freqOffset, .lo);

  complexMixer mixer (.clk, .reset, .a(in), .b(lo), .p(out));

endmodule

`default_nettype wire

// File: testbench/carrierLoopTb.sv
`default_nettype none
`include "carrierLoop_consts.svh"

module carrierLoopTb import carrierLoopPkg::*; ();

  localparam int CLK_PERIOD  = 10;
  localparam int ACK_TIMEOUT = 16;
  localparam int MIX_SAMPLES = 48;
  localparam int N_ERRORS    = 8;
  localparam int BUS_CYCLES  = 3;     // Per host access
  localparam int ERR_CYCLES  = 7;     // Per strobed error
  localparam logic [31:0] TEST_LIMIT = 32'h100;

  // Length of each test in clocks, reset first
  localparam int TOTAL_CYCLES = 4
      + 32 * BUS_CYCLES + ACK_TIMEOUT
      + MIX_SAMPLES + 4 + BUS_CYCLES
      + 3 * N_ERRORS * ERR_CYCLES + 12 * BUS_CYCLES
      + 8 * ERR_CYCLES + 5 * BUS_CYCLES
      + 21 * ERR_CYCLES + 5 * BUS_CYCLES;

  logic        clk = 1'b0;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [11:0] adr;
  logic [3:0]  sel;
  logic [31:0] datIn;
  logic [31:0] datOut;
  logic        ack;
  iqSample_t   sampleIn;
  iqSample_t   sampleOut;
  logic        symEn;
  logic        sym2xEn;
  logic [7:0]  phaseError;
  logic        symEnOut;
  logic        sym2xEnOut;
  logic        carrierLock;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] lfsr = 32'h2193f91c;

  // Loop filter reference state
  longint      modelLag;
  longint      modelSum;
  longint      modelLimit;
  int          modelLeadExp;
  int          modelLagExp;
  logic [7:0]  errSeq [N_ERRORS];

  carrierLoop uut (.clk, .reset, .cyc, .stb, .we, .adr, .sel, .datIn, .datOut, .ack,
                   .in(sampleIn), .symEn, .sym2xEn, .phaseError, .out(sampleOut),
                   .symEnOut, .sym2xEnOut, .carrierLock);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);   // Galois taps
    end
    return bits;
  endfunction

  function automatic logic [11:0] regAddr(input logic [7:0] offset);
    return {`LOOP_SPACE, offset};
  endfunction

  function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                             input logic [31:0] newWord,
                                             input logic [3:0]  byteEn);
    logic [31:0] merged;
    merged = oldWord;
    for (int i = 0; i < 4; i++) begin
      if (byteEn[i])
        merged[8*i +: 8] = newWord[8*i +: 8];
    end
    return merged;
  endfunction

  // Product with the phase zero LO, floor shift then clip
  function automatic logic signed [`SAMPLE_W-1:0] scaleByAmp(
      input logic signed [`SAMPLE_W-1:0] x);
    longint prod;
    longint maxVal;
    maxVal = (longint'(1) <<< (`SAMPLE_W - 1)) - 1;
    prod   = (longint'(x) * longint'(`NCO_AMP)) >>> (`SAMPLE_W - 1);
    if (prod > maxVal)
      prod = maxVal;
    else if (prod < -maxVal - 1)
      prod = -maxVal - 1;
    return prod[`SAMPLE_W-1:0];
  endfunction

  function automatic logic [7:0] conditionError(input logic [7:0] e, input logic invert,
                                                input logic zero);
    if (zero)
      return 8'd0;
    if (invert)
      return 8'd0 - e;
    return e;
  endfunction

  function automatic logic [31:0] upper32(input longint v);
    logic [63:0] bits;
    bits = v;
    return bits[`ACCUM_W-1 -: 32];
  endfunction

  // Error outside a threshold of 8, either sign
  function automatic logic [7:0] farError();
    logic [7:0] mag;
    mag = 8'd9 + takeBits(6);
    return takeBits(1) ? 8'd0 - mag : mag;
  endfunction

  task automatic stepModel(input logic [7:0] e);
    longint ext;
    longint next;
    ext      = longint'($signed(e));
    modelSum = modelLag + (ext <<< modelLeadExp);   // Lag before this update
    next     = modelLag + (ext <<< modelLagExp);
    if (next > modelLimit)
      next = modelLimit;
    else if (next < -modelLimit)
      next = -modelLimit;
    modelLag = next;
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    checks++;
    assert (got === expected) else begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // Host bus driver
  // ------------------------------------------------------------
  task automatic busCycle(input logic write, input logic [11:0] addr,
                          input logic [31:0] wdata, input logic [3:0] byteEn,
                          output logic [31:0] rdata, output logic gotAck);
    int n;
    @(negedge clk);
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = write;
    adr    = addr;
    datIn  = wdata;
    sel    = byteEn;
    n      = 0;
    gotAck = 1'b0;
    rdata  = '0;
    while (!gotAck && n < ACK_TIMEOUT) begin
      @(negedge clk);
      gotAck = ack;
      rdata  = datOut;          // Valid with ack
      n++;
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wbWrite(input logic [11:0] addr, input logic [31:0] data,
                         input logic [3:0] byteEn);
    logic [31:0] unused;
    logic        gotAck;
    busCycle(1'b1, addr, data, byteEn, unused, gotAck);
    assert (gotAck) else begin
      $display("Write to address %h at %0t was never acknowledged", addr, $time);
      errors++;
    end
  endtask

  task automatic wbRead(input logic [11:0] addr, output logic [31:0] data);
    logic gotAck;
    busCycle(1'b0, addr, 32'd0, 4'hF, data, gotAck);
    assert (gotAck) else begin
      $display("Read from address %h at %0t was never acknowledged", addr, $time);
      errors++;
    end
  endtask

  // One error applied on the cycle its strobe leaves the mixer
  task automatic applyError(input logic [7:0] err);
    int n;
    @(negedge clk);
    phaseError = err;
    sym2xEn    = 1'b1;
    @(negedge clk);
    sym2xEn = 1'b0;
    n       = 0;
    while (!sym2xEnOut && n < 2 * `MIX_LATENCY) begin
      @(negedge clk);
      n++;
    end
    assert (sym2xEnOut) else begin
      $display("sym2xEnOut never followed sym2xEn at %0t", $time);
      errors++;
    end
    @(negedge clk);             // Loop updated on the edge before
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic registerTest();
    logic [7:0]  offset;
    logic [31:0] mask;
    logic [31:0] expWord;
    logic [31:0] data;
    logic [31:0] rd;
    logic [3:0]  byteEn;
    logic        gotAck;
    for (int r = 0; r < 4; r++) begin
      case (r)
        0:       begin offset = `REG_CONTROL; mask = 32'h0000_0007; end
        1:       begin offset = `REG_GAINS;   mask = 32'h0000_1F1F; end
        2:       begin offset = `REG_LIMIT;   mask = 32'hFFFF_FFFF; end
        default: begin offset = `REG_LOCK;    mask = 32'h00FF_FFFF; end
      endcase
      data = takeBits(32);
      wbWrite(regAddr(offset), data, 4'hF);
      expWord = data & mask;
      wbRead(regAddr(offset), rd);
      checkValue("datOut", rd, expWord);
      for (int k = 0; k < 3; k++) begin
        data   = takeBits(32);
        byteEn = takeBits(4);
        wbWrite(regAddr(offset), data, byteEn);
        expWord = mergeBytes(expWord, data, byteEn) & mask;
        wbRead(regAddr(offset), rd);
        checkValue("datOut", rd, expWord);
      end
    end
    busCycle(1'b0, {`LOOP_SPACE ^ 4'h9, `REG_LIMIT}, 32'd0, 4'hF, rd, gotAck);
    assert (!gotAck) else begin
      $display("Access outside the block was acknowledged at %0t", $time);
      errors++;
    end
  endtask

  task automatic mixerTest();
    iqSample_t  expOut [4];
    iqSample_t  sample;
    logic [3:0] expSym;
    logic [3:0] expSym2x;
    logic       sEn;
    logic       s2En;
    wbWrite(regAddr(`REG_CONTROL), 32'h6, 4'hF);   // Loop open, NCO stays at phase zero
    expSym   = '0;
    expSym2x = '0;
    for (int i = 0; i < 4; i++) begin
      expOut[i] = '0;
    end
    for (int k = 0; k < MIX_SAMPLES + 4; k++) begin
      @(negedge clk);
      checkValue("symEnOut", {31'd0, symEnOut}, {31'd0, expSym[3]});
      checkValue("sym2xEnOut", {31'd0, sym2xEnOut}, {31'd0, expSym2x[3]});
      checkValue("out.re", sampleOut.re, expOut[3].re);
      checkValue("out.im", sampleOut.im, expOut[3].im);
      sample = '0;
      sEn    = 1'b0;
      s2En   = 1'b0;
      if (k < MIX_SAMPLES) begin
        sample.re = takeBits(`SAMPLE_W);
        sample.im = takeBits(`SAMPLE_W);
        sEn       = takeBits(1);
        s2En      = takeBits(1);
      end
      sampleIn = sample;
      symEn    = sEn;
      sym2xEn  = s2En;
      expSym   = {expSym[2:0], sEn};
      expSym2x = {expSym2x[2:0], s2En};
      for (int i = 3; i > 0; i--) begin
        expOut[i] = expOut[i-1];
      end
      expOut[0].re = scaleByAmp(sample.re);
      expOut[0].im = scaleByAmp(sample.im);
    end
  endtask

  task automatic runErrors(input logic invert, input logic zero,
                           output logic [31:0] lagRead);
    logic [31:0] freqRead;
    for (int i = 0; i < N_ERRORS; i++) begin
      applyError(errSeq[i]);
      stepModel(conditionError(errSeq[i], invert, zero));
    end
    wbRead(regAddr(`REG_LAGACCUM), lagRead);
    checkValue("lagAccum", lagRead, upper32(modelLag));
    wbRead(regAddr(`REG_FREQ), freqRead);
    checkValue("freqOffset", freqRead, upper32(modelSum));
  endtask

  task automatic loopTest();
    logic [31:0] lagPlain;
    logic [31:0] lagInv;
    logic [31:0] lagZero;
    modelLeadExp = 20;
    modelLagExp  = 12;
    modelLimit   = longint'(32'h7FFF_FFFF) <<< 8;
    modelLag     = 0;           // Held clear by the mixer test
    modelSum     = 0;
    wbWrite(regAddr(`REG_LIMIT), 32'h7FFF_FFFF, 4'hF);
    wbWrite(regAddr(`REG_GAINS), {19'd0, 5'd12, 3'd0, 5'd20}, 4'hF);
    for (int i = 0; i < N_ERRORS; i++) begin
      errSeq[i] = takeBits(8);
      if (errSeq[i] == 8'h80)
        errSeq[i] = 8'h81;      // -128 has no 8 bit negation
    end
    wbWrite(regAddr(`REG_CONTROL), 32'h0, 4'hF);
    runErrors(1'b0, 1'b0, lagPlain);
    wbWrite(regAddr(`REG_CONTROL), 32'h4, 4'hF);
    modelLag = 0;
    wbWrite(regAddr(`REG_CONTROL), 32'h1, 4'hF);
    runErrors(1'b1, 1'b0, lagInv);
    checkValue("lagAccum", lagInv, 32'd0 - lagPlain);
    wbWrite(regAddr(`REG_CONTROL), 32'h2, 4'hF);
    runErrors(1'b0, 1'b1, lagZero);
    checkValue("lagAccum", lagZero, lagInv);
  endtask

  task automatic limitTest();
    logic [31:0] rd;
    wbWrite(regAddr(`REG_CONTROL), 32'h4, 4'hF);
    wbWrite(regAddr(`REG_LIMIT), TEST_LIMIT, 4'hF);
    wbWrite(regAddr(`REG_CONTROL), 32'h0, 4'hF);
    for (int i = 0; i < 4; i++) begin
      applyError(8'd64 + takeBits(6));
    end
    wbRead(regAddr(`REG_LAGACCUM), rd);
    checkValue("lagAccum", rd, TEST_LIMIT);
    for (int i = 0; i < 4; i++) begin
      applyError(8'd192 - takeBits(6));   // -64 down to -127
    end
    wbRead(regAddr(`REG_LAGACCUM), rd);
    checkValue("lagAccum", rd, 32'd0 - TEST_LIMIT);
  endtask

  task automatic lockTest();
    logic [7:0]  nearErr;
    logic [31:0] rd;
    wbWrite(regAddr(`REG_CONTROL), 32'h4, 4'hF);
    wbWrite(regAddr(`REG_LOCK), {8'd0, 8'd8, 16'hFFF0}, 4'hF);
    for (int i = 0; i < 16; i++) begin
      nearErr = takeBits(4) - 32'd8;      // -8 to 7
      applyError(nearErr);
    end
    checkValue("carrierLock", {31'd0, carrierLock}, 32'd1);
    wbRead(regAddr(`REG_STATUS), rd);
    checkValue("lockCounter", rd, 32'h0001_FFF0);
    // Short reload so the counter runs out quickly
    wbWrite(regAddr(`REG_LOCK), {8'd0, 8'd8, 16'd4}, 4'hF);
    for (int i = 0; i < 4; i++) begin
      applyError(farError());
    end
    checkValue("carrierLock", {31'd0, carrierLock}, 32'd1);
    applyError(farError());
    checkValue("carrierLock", {31'd0, carrierLock}, 32'd0);
    wbRead(regAddr(`REG_STATUS), rd);
    checkValue("lockCounter", rd, 32'h0000_0004);
  endtask

  // ------------------------------------------------------------
  // Sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    reset      = 1'b1;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = '0;
    sel        = '0;
    datIn      = '0;
    sampleIn   = '0;
    symEn      = 1'b0;
    sym2xEn    = 1'b0;
    phaseError = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    registerTest();
    mixerTest();
    loopTest();
    limitTest();
    lockTest();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial begin
    #(2 * TOTAL_CYCLES * CLK_PERIOD);
    errors++;
    $display("Timeout: tests still running after %0d clocks", 2 * TOTAL_CYCLES);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/carrierLoopPkg.sv
src/loopRegs.sv
src/carrierLoopCtrl.sv
src/loopFilter.sv
src/carrierNco.sv
src/complexMixer.sv
src/carrierLoop.sv
testbench/carrierLoopTb.sv
